//--- Bender.yml
package:
  name: pcs_tx

sources:
  # rtl
  - source/pcs_pkg.sv
  - source/pcs_tx_enc.sv
  - source/pcs_tx_scrambler.sv
  - source/pcs_tx_top.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/pcs_tx_assert.sv
      - sim/tb_pcs_tx.sv

//--- filelist.f
source/pcs_pkg.sv
source/pcs_tx_enc.sv
source/pcs_tx_scrambler.sv
source/pcs_tx_top.sv
sim/tb_clk_gen.sv
sim/pcs_tx_assert.sv
sim/tb_pcs_tx.sv

//--- sim/pcs_tx_assert.sv
`timescale 1ns/1ps

module pcs_tx_assert (
	input logic                clk,
	input logic                nreset,
	input pcs_pkg::xgmii_tx_s  tx_i,
	input pcs_pkg::enc_state_e state_i,
	input pcs_pkg::pcs_block_s block_i,
	input logic                block_v_i
);

	int fail_cnt = 0; // assertion failures so far

	// only the three defined states
	state_legal: assert property (@(posedge clk) disable iff (!nreset)
		state_i inside {pcs_pkg::ENC_IDLE, pcs_pkg::ENC_DATA, pcs_pkg::ENC_TERM_DLY})
	else begin
		$error("encoder state register holds an undefined encoding");
		fail_cnt++;
	end

	// the cycle after a full last word carries no frame data
	full_last_then_idle: assert property (@(posedge clk) disable iff (!nreset)
		(tx_i.last && tx_i.keep == '1) |=> tx_i.idle)
	else begin
		$error("full last word was not followed by an idle word");
		fail_cnt++;
	end

	sync_legal: assert property (@(posedge clk) disable iff (!nreset)
		block_v_i |-> (block_i.sync == pcs_pkg::SYNC_DATA || block_i.sync == pcs_pkg::SYNC_CTRL))
	else begin
		$error("encoder produced an invalid sync header");
		fail_cnt++;
	end

endmodule

bind pcs_tx_enc pcs_tx_assert i_enc_assert (
	.clk      (clk),
	.nreset   (nreset),
	.tx_i     (tx_i),
	.state_i  (state_q),
	.block_i  (block_o),
	.block_v_i(block_v_o)
);

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic nreset_o
);

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever begin
			#4 clk_o = ~clk_o;
		end
	end

	initial begin
		nreset_o = 1'b0;
		repeat (8) @(posedge clk_o); // reset held for 8 cycles
		nreset_o <= 1'b1;
	end

endmodule

//--- sim/tb_pcs_tx.sv
`timescale 1ns/1ps

module tb_pcs_tx;

	logic                clk;
	logic                nreset;
	pcs_pkg::xgmii_tx_s  tx_word;
	pcs_pkg::pcs_block_s dut_block;
	logic                dut_block_v;

	pcs_pkg::xgmii_tx_s word_q[$]; // every word driven in order
	int                 total_words = 0;
	logic               stim_done = 1'b0;
	logic [31:0]        rand_state = 32'h27cc0890;

	// reference model state
	logic                ref_term_owed = 1'b0;
	pcs_pkg::scr_state_t ref_hist = pcs_pkg::SCR_SEED;

	tb_clk_gen i_clk_gen (
		.clk_o   (clk),
		.nreset_o(nreset)
	);

	pcs_tx_top i_dut (
		.clk      (clk),
		.nreset   (nreset),
		.tx_i     (tx_word),
		.block_o  (dut_block),
		.block_v_o(dut_block_v)
	);

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic int rand_below(input int n);
		return int'((next_rand() >> 8) % n); // upper bits of the generator
	endfunction

	function automatic pcs_pkg::xgmii_data_t rand_data();
		return {next_rand(), next_rand()};
	endfunction

	// eight control characters of 7 bits each
	function automatic pcs_pkg::ctrl_body_t ctrl_fill(input pcs_pkg::ctrl_char_t ch);
		pcs_pkg::ctrl_body_t body;
		for (int i = 0; i < 8; i++) begin
			body[7*i +: 7] = ch;
		end
		return body;
	endfunction

	function automatic int count_bytes(input pcs_pkg::xgmii_keep_t keep);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++) begin
			n += keep[i];
		end
		return n;
	endfunction

	function automatic pcs_pkg::block_type_t term_type(input int k);
		case (k)
			0:       return pcs_pkg::BT_TERM_0;
			1:       return pcs_pkg::BT_TERM_1;
			2:       return pcs_pkg::BT_TERM_2;
			3:       return pcs_pkg::BT_TERM_3;
			4:       return pcs_pkg::BT_TERM_4;
			5:       return pcs_pkg::BT_TERM_5;
			6:       return pcs_pkg::BT_TERM_6;
			default: return pcs_pkg::BT_TERM_7;
		endcase
	endfunction

	// expected unscrambled block for one input word
	function automatic pcs_pkg::pcs_block_s ref_encode(input pcs_pkg::xgmii_tx_s w);
		pcs_pkg::pcs_block_s b;
		int k;
		b.sync    = pcs_pkg::SYNC_CTRL;
		b.payload = {ctrl_fill(pcs_pkg::CTRL_IDLE), pcs_pkg::BT_CTRL};
		if (ref_term_owed) begin
			b.payload[7:0] = pcs_pkg::BT_TERM_0; // replaces the idle after a full last word
			ref_term_owed  = 1'b0;
		end else if (w.err) begin
			b.payload = {ctrl_fill(pcs_pkg::CTRL_ERROR), pcs_pkg::BT_CTRL};
		end else if (w.idle) begin
			b.payload = {ctrl_fill(pcs_pkg::CTRL_IDLE), pcs_pkg::BT_CTRL};
		end else if (w.start) begin
			b.payload = {w.data[63:8], pcs_pkg::BT_START_0}; // byte 0 is the start position
		end else if (w.last) begin
			k = count_bytes(w.keep);
			if (k == 8) begin
				b.sync        = pcs_pkg::SYNC_DATA;
				b.payload     = w.data;
				ref_term_owed = 1'b1;
			end else begin
				b.payload[7:0] = term_type(k);
				for (int j = 0; j < k; j++) begin
					b.payload[8 + 8*j +: 8] = w.data[8*j +: 8]; // data byte j in block byte j+1
				end
			end
		end else begin
			b.sync    = pcs_pkg::SYNC_DATA;
			b.payload = w.data;
		end
		return b;
	endfunction

	// x^58 + x^39 + 1 over the payload with the LSB first
	function automatic pcs_pkg::xgmii_data_t ref_scramble(input pcs_pkg::xgmii_data_t d);
		pcs_pkg::xgmii_data_t s;
		logic                 o;
		for (int i = 0; i < 64; i++) begin
			o        = d[i] ^ ref_hist[38] ^ ref_hist[57];
			s[i]     = o;
			ref_hist = {ref_hist[56:0], o};
		end
		return s;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic send_word(input pcs_pkg::xgmii_tx_s w);
		tx_word <= w;
		word_q.push_back(w);
		total_words++;
		@(posedge clk);
	endtask

	task automatic send_idle(input int n);
		pcs_pkg::xgmii_tx_s w;
		w      = '0;
		w.idle = 1'b1;
		repeat (n) send_word(w);
	endtask

	task automatic send_err();
		pcs_pkg::xgmii_tx_s w;
		w      = '0;
		w.err  = 1'b1;
		w.data = rand_data(); // ignored by the encoder
		send_word(w);
	endtask

	task automatic send_start();
		pcs_pkg::xgmii_tx_s w;
		w       = '0;
		w.start = 1'b1;
		w.keep  = '1;
		w.data  = rand_data();
		send_word(w);
	endtask

	task automatic send_data(input int n);
		pcs_pkg::xgmii_tx_s w;
		repeat (n) begin
			w      = '0;
			w.keep = '1;
			w.data = rand_data();
			send_word(w);
		end
	endtask

	// len counts the words after start including the last one
	task automatic send_frame(input int len, input int k);
		pcs_pkg::xgmii_tx_s w;
		logic [8:0]         mask;
		mask = (9'd1 << k) - 9'd1;
		send_start();
		send_data(len - 1);
		w      = '0;
		w.last = 1'b1;
		w.keep = mask[7:0];
		w.data = rand_data();
		send_word(w);
		if (k == 8) begin
			send_idle(1); // slot for the owed terminate
		end
	endtask

	initial begin : stimulus
		pcs_pkg::xgmii_tx_s w;
		int k;
		w       = '0;
		w.idle  = 1'b1;
		tx_word = w;
		while (nreset !== 1'b1) @(posedge clk);
		// this word is the first one sampled out of reset
		word_q.push_back(w);
		total_words++;

		$display("idle run after reset");
		send_idle(12);

		$display("frames with partial last words");
		repeat (30) begin
			send_frame(1 + rand_below(20), 1 + rand_below(7));
			send_idle(1 + rand_below(3));
		end

		$display("frames with full last words");
		repeat (10) begin
			send_frame(1 + rand_below(20), 8);
			send_idle(rand_below(3));
		end

		$display("error words");
		send_err(); // outside a frame
		send_idle(2);
		send_frame(3, 4);
		send_start();
		send_data(2);
		send_err(); // aborts the open frame
		send_frame(2, 5);
		send_idle(1);
		send_err();
		send_frame(1, 0);
		send_idle(2);

		$display("long back to back stream");
		repeat (200) begin
			k = rand_below(9);
			send_frame(1 + rand_below(20), k);
			send_idle(rand_below(3));
		end
		send_idle(4);
		stim_done = 1'b1;
	end

	initial begin : compare
		pcs_pkg::xgmii_tx_s  w;
		pcs_pkg::pcs_block_s exp;
		int                  low_cycles;
		logic                seen_valid;
		logic                done;
		low_cycles = 0;
		seen_valid = 1'b0;
		done       = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (i_dut.i_enc.i_enc_assert.fail_cnt != 0) begin
				stop_on_error("an encoder assertion failed");
			end
			if (dut_block_v !== 1'b1) begin
				if (seen_valid) begin
					stop_on_error("block_v_o dropped low after it had gone high");
				end
				if (nreset === 1'b1) begin
					low_cycles++;
				end
			end else begin
				if (!seen_valid) begin
					seen_valid = 1'b1;
					check_val("block_v_o low cycles after reset", low_cycles, 2);
				end
				if (word_q.size() == 0) begin
					if (stim_done) begin
						done = 1'b1;
					end else begin
						stop_on_error("valid output block with no input word queued");
					end
				end else begin
					w           = word_q.pop_front();
					exp         = ref_encode(w);
					exp.payload = ref_scramble(exp.payload);
					check_val("block_o.sync", dut_block.sync, exp.sync);
					check_val("block_o.payload", dut_block.payload, exp.payload);
				end
			end
		end
		if (i_dut.i_enc.i_enc_assert.fail_cnt == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stop_on_error("encoder assertions failed during the run");
		end
	end

	initial begin : timeout
		int cycles;
		cycles = 0;
		while (cycles <= 40 * total_words + 100) begin
			@(posedge clk);
			cycles++;
		end
		stop_on_error($sformatf("timeout after %0d cycles, output blocks stopped arriving",
			cycles));
	end

endmodule

//--- source/pcs_pkg.sv
package pcs_pkg;

	// widths
	localparam int XGMII_DATA_W = 64;
	localparam int XGMII_KEEP_W = 8;
	localparam int BLOCK_TYPE_W = 8;
	localparam int SYNC_W       = 2;
	localparam int CTRL_W       = 7;
	localparam int CTRL_N       = 8; // control characters in an all-control block
	localparam int CTRL_BODY_W  = XGMII_DATA_W - BLOCK_TYPE_W; // payload above the type byte
	localparam int SCR_W        = 58;

	typedef logic [XGMII_DATA_W-1:0] xgmii_data_t;
	typedef logic [XGMII_KEEP_W-1:0] xgmii_keep_t; // contiguous from byte 0
	typedef logic [BLOCK_TYPE_W-1:0] block_type_t;
	typedef logic [SYNC_W-1:0]       sync_head_t;
	typedef logic [CTRL_W-1:0]       ctrl_char_t;
	typedef logic [CTRL_BODY_W-1:0]  ctrl_body_t;
	typedef logic [SCR_W-1:0]        scr_state_t;

	// sync header
	localparam sync_head_t SYNC_DATA = 2'b01;
	localparam sync_head_t SYNC_CTRL = 2'b10;

	// control characters, 7 bits each on the line
	localparam ctrl_char_t CTRL_IDLE  = 7'h00;
	localparam ctrl_char_t CTRL_ERROR = 7'h1e;

	// block types
	localparam block_type_t BT_CTRL    = 8'h1e; // C7 C6 C5 C4 C3 C2 C1 C0
	localparam block_type_t BT_START_0 = 8'h78; // D7 .. D1, start in lane 0
	localparam block_type_t BT_TERM_0  = 8'h87;
	localparam block_type_t BT_TERM_1  = 8'h99;
	localparam block_type_t BT_TERM_2  = 8'haa;
	localparam block_type_t BT_TERM_3  = 8'hb4;
	localparam block_type_t BT_TERM_4  = 8'hcc;
	localparam block_type_t BT_TERM_5  = 8'hd2;
	localparam block_type_t BT_TERM_6  = 8'he1;
	localparam block_type_t BT_TERM_7  = 8'hff; // seven data bytes, no control

	// scrambler history after reset
	localparam scr_state_t SCR_SEED = {SCR_W{1'b1}};

	typedef enum logic [1:0] {
		ENC_IDLE     = 2'd0, // between frames
		ENC_DATA     = 2'd1, // inside a frame
		ENC_TERM_DLY = 2'd2  // full last word sent, terminate still owed
	} enc_state_e;

	// one transmit word, exactly one strobe or none (plain data)
	typedef struct packed {
		logic        idle;
		logic        start;
		logic        last;
		logic        err;
		xgmii_keep_t keep;
		xgmii_data_t data;
	} xgmii_tx_s;

	// one 66-bit block, type byte in payload[7:0] for control blocks
	typedef struct packed {
		sync_head_t  sync;
		xgmii_data_t payload;
	} pcs_block_s;

endpackage

//--- source/pcs_tx_enc.sv
`timescale 1ns/1ps

module pcs_tx_enc (
	input  logic                clk,
	input  logic                nreset,
	input  pcs_pkg::xgmii_tx_s  tx_i,
	output pcs_pkg::pcs_block_s block_o,
	output logic                block_v_o
);

	pcs_pkg::enc_state_e state_q;
	pcs_pkg::enc_state_e state_next;

	// terminate type from keep
	logic [pcs_pkg::XGMII_KEEP_W:0] term_mask; // keep + 1, one-hot for a contiguous mask
	logic                           keep_full;
	pcs_pkg::block_type_t           term_type;

	// payload pieces
	pcs_pkg::ctrl_body_t idle_chars;
	pcs_pkg::ctrl_body_t err_chars;
	pcs_pkg::ctrl_body_t keep_bits;
	pcs_pkg::ctrl_body_t term_body;

	// next block
	logic                 data_blk;
	pcs_pkg::block_type_t type_next;
	pcs_pkg::ctrl_body_t  body_next;
	pcs_pkg::pcs_block_s  block_next;
	logic                 term_delay;

	assign term_delay = state_q == pcs_pkg::ENC_TERM_DLY;

	// a contiguous keep plus one lands on a single bit,
	// the position of that bit is the byte count
	assign term_mask = {1'b0, tx_i.keep} + {{pcs_pkg::XGMII_KEEP_W{1'b0}}, 1'b1};
	assign keep_full = term_mask[pcs_pkg::XGMII_KEEP_W]; // carried out, all eight bytes

	always_comb begin
		case (term_mask)
			9'b0_0000_0001: term_type = pcs_pkg::BT_TERM_0;
			9'b0_0000_0010: term_type = pcs_pkg::BT_TERM_1;
			9'b0_0000_0100: term_type = pcs_pkg::BT_TERM_2;
			9'b0_0000_1000: term_type = pcs_pkg::BT_TERM_3;
			9'b0_0001_0000: term_type = pcs_pkg::BT_TERM_4;
			9'b0_0010_0000: term_type = pcs_pkg::BT_TERM_5;
			9'b0_0100_0000: term_type = pcs_pkg::BT_TERM_6;
			9'b0_1000_0000: term_type = pcs_pkg::BT_TERM_7;
			default:        term_type = pcs_pkg::BT_TERM_0; // full keep is sent as data
		endcase
	end

	assign idle_chars = {pcs_pkg::CTRL_N{pcs_pkg::CTRL_IDLE}};
	assign err_chars  = {pcs_pkg::CTRL_N{pcs_pkg::CTRL_ERROR}};

	// byte mask for data bytes 0..6, which sit in block bytes 1..7
	always_comb begin
		for (int j = 0; j < pcs_pkg::XGMII_KEEP_W - 1; j++) begin
			keep_bits[j*8 +: 8] = {8{tx_i.keep[j]}};
		end
	end

	// kept bytes first, idle characters fill the rest
	assign term_body = (tx_i.data[pcs_pkg::CTRL_BODY_W-1:0] & keep_bits)
		| (idle_chars & ~keep_bits);

	always_comb begin
		data_blk   = 1'b0;
		type_next  = pcs_pkg::BT_CTRL;
		body_next  = idle_chars;
		state_next = state_q;
		if (term_delay) begin
			// the idle input word is replaced by the owed terminate
			type_next  = pcs_pkg::BT_TERM_0;
			state_next = pcs_pkg::ENC_IDLE;
		end else if (tx_i.err) begin
			body_next  = err_chars; // abort
			state_next = pcs_pkg::ENC_IDLE;
		end else if (tx_i.idle) begin
			state_next = pcs_pkg::ENC_IDLE;
		end else if (tx_i.start) begin
			type_next  = pcs_pkg::BT_START_0;
			body_next  = tx_i.data[pcs_pkg::XGMII_DATA_W-1:pcs_pkg::BLOCK_TYPE_W];
			state_next = pcs_pkg::ENC_DATA;
		end else if (tx_i.last && keep_full) begin
			// no room for a type byte, terminate goes in the next block
			data_blk   = 1'b1;
			state_next = pcs_pkg::ENC_TERM_DLY;
		end else if (tx_i.last) begin
			type_next  = term_type;
			body_next  = term_body;
			state_next = pcs_pkg::ENC_IDLE;
		end else begin
			data_blk = 1'b1; // plain frame word
		end
	end

	assign block_next.sync    = data_blk ? pcs_pkg::SYNC_DATA : pcs_pkg::SYNC_CTRL;
	assign block_next.payload = data_blk ? tx_i.data : {body_next, type_next};

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state_q   <= pcs_pkg::ENC_IDLE;
			block_v_o <= 1'b0;
		end else begin
			state_q   <= state_next;
			block_v_o <= 1'b1; // one block for every word once out of reset
		end
	end

	always_ff @(posedge clk) begin
		block_o <= block_next;
	end

endmodule

//--- source/pcs_tx_scrambler.sv
`timescale 1ns/1ps

module pcs_tx_scrambler (
	input  logic                clk,
	input  logic                nreset,
	input  pcs_pkg::pcs_block_s block_i,
	input  logic                block_v_i,
	output pcs_pkg::pcs_block_s block_o,
	output logic                block_v_o
);

	pcs_pkg::scr_state_t  scr_q;    // history, bit 0 is the most recent output bit
	pcs_pkg::scr_state_t  scr_next;
	pcs_pkg::xgmii_data_t payload_scr;

	// x^58 + x^39 + 1, one bit at a time, LSB of the payload first
	always_comb begin
		logic out_bit;
		scr_next    = scr_q;
		payload_scr = '0;
		for (int i = 0; i < pcs_pkg::XGMII_DATA_W; i++) begin
			out_bit        = block_i.payload[i] ^ scr_next[38] ^ scr_next[57];
			payload_scr[i] = out_bit;
			scr_next       = {scr_next[pcs_pkg::SCR_W-2:0], out_bit}; // feed back the output
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			scr_q     <= pcs_pkg::SCR_SEED;
			block_v_o <= 1'b0;
		end else begin
			block_v_o <= block_v_i;
			if (block_v_i) begin
				scr_q <= scr_next; // history carries over to the next block
			end
		end
	end

	// sync header rides along unscrambled in the same stage
	always_ff @(posedge clk) begin
		if (block_v_i) begin
			block_o.sync    <= block_i.sync;
			block_o.payload <= payload_scr;
		end
	end

endmodule

//--- source/pcs_tx_top.sv
`timescale 1ns/1ps

module pcs_tx_top (
	input  logic                clk,
	input  logic                nreset,
	input  pcs_pkg::xgmii_tx_s  tx_i,
	output pcs_pkg::pcs_block_s block_o,
	output logic                block_v_o
);

	pcs_pkg::pcs_block_s enc_block; // unscrambled block, one cycle after tx_i
	logic                enc_v;

	// 64b/66b encoder
	pcs_tx_enc i_enc (
		.clk      (clk),
		.nreset   (nreset),
		.tx_i     (tx_i),
		.block_o  (enc_block),
		.block_v_o(enc_v)
	);

	// payload scrambler, adds the second cycle of latency
	pcs_tx_scrambler i_scrambler (
		.clk      (clk),
		.nreset   (nreset),
		.block_i  (enc_block),
		.block_v_i(enc_v),
		.block_o  (block_o),
		.block_v_o(block_v_o)
	);

endmodule
